// ==== files.f ====
dz_pkg.sv
apb_pkg.sv
glyph_rom.sv
frame_ram.sv
frame_arbiter.sv
apb_regs.sv
dz_scan.sv
dz_top.sv
tb_dz_top.sv

// ==== tb_dz_top.sv ====
`timescale 1ns/1ps

module tb_dz_top;
    import apb_pkg::*;
    import dz_pkg::*;

    localparam int SEED    = 93;
    localparam int TIMEOUT = 64;  // cycles allowed per wait
    localparam int N_TESTS = 13;

    typedef struct packed {
        logic [7:0]  ctrl;
        logic        wr_ram;  // load the user frame first
        logic [63:0] green;   // row 0 in the top byte
        logic [63:0] red;
    } entry_t;

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    dz_row_t  row;
    dz_row_t  colg;
    dz_row_t  colr;

    entry_t      table_e [N_TESTS];
    string       test_name [N_TESTS];
    logic [15:0] ram_word [8];
    string       cur_test;
    int          n_entries;
    int          errors;
    int          tests;
    int          failed_tests;
    int          test_err0;

    dz_top u_dz_top (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .row     (row),
        .colg    (colg),
        .colr    (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_entry(input string name, input logic [7:0] ctrl, input logic wr,
                             input logic [63:0] g, input logic [63:0] r);
        test_name[n_entries]      = name;
        table_e[n_entries].ctrl   = ctrl;
        table_e[n_entries].wr_ram = wr;
        table_e[n_entries].green  = g;
        table_e[n_entries].red    = r;
        n_entries++;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors != test_err0)
        begin
            failed_tests++;
            $display("test %-14s %0d error(s)", cur_test, errors - test_err0);
        end
        else
            $display("test %-14s ok", cur_test);
    endtask

    // one APB transfer with pready polled at the falling edge
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int  n;
        logic ok;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        n     = 0;
        ok    = 1'b0;
        rdata = '0;
        err   = 1'b0;
        while (!ok && n < TIMEOUT)
        begin
            @(negedge clk);
            if (apb_rsp.pready)
            begin
                ok    = 1'b1;
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
            end
            n++;
        end
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        if (!ok)
        begin
            $display("%s: timeout, pready never came for address %h", cur_test, addr);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
        if (err)
        begin
            $display("FAILED %s: pslverr at %h expected 0 actual 1", cur_test, addr);
            errors++;
        end
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, '0, rdata, err);
        if (err || rdata !== exp)
        begin
            $display("FAILED %s: read %h expected %h actual %h (pslverr %b)",
                     cur_test, addr, exp, rdata, err);
            errors++;
        end
    endtask

    // index of the single low bit or -1 if none or several
    function automatic int low_bit(input dz_row_t sel);
        int pos;
        int n;
        pos = -1;
        n   = 0;
        for (int i = 0; i < 8; i++)
        begin
            if (!sel[i])
            begin
                pos = i;
                n++;
            end
        end
        return (n == 1) ? pos : -1;
    endfunction

    task automatic check_blank(input int periods);
        int n;
        n = 0;
        while (n < periods * ROW_CYCLES)
        begin
            @(negedge clk);
            if (row !== 8'hff || colg !== 8'h00 || colr !== 8'h00)
            begin
                $display("FAILED %s: row/colg/colr expected ff/00/00 actual %h/%h/%h",
                         cur_test, row, colg, colr);
                errors++;
                n = periods * ROW_CYCLES;  // stop at the first mismatch
            end
            n++;
        end
    endtask

    task automatic wait_row0(output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < TIMEOUT)
        begin
            @(negedge clk);
            ok = (row === 8'hfe);
            n++;
        end
    endtask

    task automatic check_scan(input int t);
        int      k;
        logic    ok;
        dz_row_t sel;
        dz_row_t eg;
        dz_row_t er;
        wait_row0(ok);
        if (!ok)
        begin
            $display("%s: timeout, row 0 never selected", cur_test);
            errors++;
        end
        for (k = 0; ok && k < 8; k++)
        begin
            sel = ~(8'h01 << k);
            eg  = table_e[t].green[63 - 8 * k -: 8];
            er  = table_e[t].red[63 - 8 * k -: 8];
            if (low_bit(row) != k)
            begin
                $display("FAILED %s: row expected %h actual %h", cur_test, sel, row);
                errors++;
            end
            else if (colg !== eg || colr !== er)
            begin
                $display("FAILED %s: row %0d colg/colr expected %h/%h actual %h/%h",
                         cur_test, k, eg, er, colg, colr);
                errors++;
            end
            repeat (ROW_CYCLES) @(negedge clk);
        end
    endtask

    initial
    begin
        logic [63:0] ram_g;
        logic [63:0] ram_r;
        logic [63:0] ram_or;
        logic [31:0] rdata;
        logic        err;
        apb_req      = '0;
        rst          = 1'b1;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        n_entries    = 0;
        void'($urandom(SEED));
        for (int r = 0; r < 8; r++)
        begin
            ram_word[r]           = 16'($urandom());
            ram_g[63 - 8 * r -: 8]  = ram_word[r][7:0];
            ram_r[63 - 8 * r -: 8]  = ram_word[r][15:8];
            ram_or[63 - 8 * r -: 8] = ram_word[r][15:8] | ram_word[r][7:0];
        end

        // glyph rows copied from the frame list with row 0 first
        add_entry("rom_f0", 8'h01, 1'b0, 64'h0000183c3c180000, 64'h0);
        add_entry("rom_f5", 8'h51, 1'b0, 64'hffffffffffffffff, 64'h0);
        add_entry("rom_f6", 8'h61, 1'b0, 64'hc3e3f1e3c7e7f7fb, 64'h0);
        add_entry("rom_f8", 8'h81, 1'b0, 64'h0038445a4a32c438, 64'h0);
        add_entry("rom_f11", 8'hb1, 1'b0, 64'he060e03031333e1c, 64'h0);
        add_entry("alarm_f0", 8'h03, 1'b0, 64'h0000183c3c180000, 64'h0000183c3c180000);
        add_entry("alarm_f5", 8'h53, 1'b0, 64'hffffffffffffffff, 64'hffffffffffffffff);
        add_entry("alarm_f6", 8'h63, 1'b0, 64'hc3e3f1e3c7e7f7fb, 64'hc3e3f1e3c7e7f7fb);
        add_entry("alarm_f8", 8'h83, 1'b0, 64'h0038445a4a32c438, 64'h0038445a4a32c438);
        add_entry("alarm_f11", 8'hb3, 1'b0, 64'he060e03031333e1c, 64'he060e03031333e1c);
        add_entry("alarm_f13", 8'hd3, 1'b0, 64'h0, 64'h0);
        add_entry("ram_frame", 8'h05, 1'b1, ram_g, ram_r);
        add_entry("ram_alarm", 8'h07, 1'b1, ram_g, ram_or);

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset_blank");
        check_blank(16);
        end_test();

        for (int t = 0; t < n_entries; t++)
        begin
            begin_test(test_name[t]);
            if (table_e[t].wr_ram)
            begin
                for (int r = 0; r < 8; r++)
                    write_reg(FRAME_BASE + 8'(4 * r), {16'h0, ram_word[r]});
            end
            write_reg(CTRL_ADDR, {24'h0, table_e[t].ctrl});
            repeat (2 * ROW_CYCLES) @(negedge clk);
            check_scan(t);
            end_test();
        end

        // scanner keeps the port busy during these reads
        begin_test("ram_readback");
        for (int r = 0; r < 8; r++)
            read_check(FRAME_BASE + 8'(4 * r), {16'h0, ram_word[r]});
        read_check(CTRL_ADDR, 32'h07);
        end_test();

        begin_test("bad_address");
        apb_access(1'b1, 8'h10, 32'hff, rdata, err);
        if (err !== 1'b1)
        begin
            $display("FAILED %s: pslverr expected 1 actual %b", cur_test, err);
            errors++;
        end
        read_check(CTRL_ADDR, 32'h07);
        end_test();

        begin_test("disable");
        write_reg(CTRL_ADDR, 32'h0);
        repeat (2) @(negedge clk);
        check_blank(16);
        end_test();

        $display("tests %0d, failing %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== dz_top.sv ====
`timescale 1ns/1ps

module dz_top (
    input  logic              clk,
    input  logic              rst,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output dz_pkg::dz_row_t   row,
    output dz_pkg::dz_row_t   colg,
    output dz_pkg::dz_row_t   colr
);
    import dz_pkg::*;

    dz_ctrl_t ctrl;
    logic     host_req;
    logic     host_we;
    logic     host_gnt;
    dz_idx_t  host_row;
    dz_cell_t host_wdata;
    dz_cell_t ram_rdata;
    logic     scan_req;
    dz_idx_t  scan_row;

    apb_regs u_apb_regs (
        .clk        (clk),
        .rst        (rst),
        .req        (apb_req),
        .rsp        (apb_rsp),
        .ctrl       (ctrl),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_row   (host_row),
        .host_wdata (host_wdata),
        .host_gnt   (host_gnt),
        .ram_rdata  (ram_rdata)
    );

    frame_arbiter u_frame_arbiter (
        .clk        (clk),
        .rst        (rst),
        .scan_req   (scan_req),
        .scan_row   (scan_row),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_row   (host_row),
        .host_wdata (host_wdata),
        .host_gnt   (host_gnt),
        .ram_rdata  (ram_rdata)
    );

    dz_scan u_dz_scan (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .scan_req  (scan_req),
        .scan_row  (scan_row),
        .ram_rdata (ram_rdata),
        .row       (row),
        .colg      (colg),
        .colr      (colr)
    );

endmodule

// ==== dz_scan.sv ====
`timescale 1ns/1ps

module dz_scan (
    input  logic             clk,
    input  logic             rst,
    input  dz_pkg::dz_ctrl_t ctrl,
    output logic             scan_req,
    output dz_pkg::dz_idx_t  scan_row,
    input  dz_pkg::dz_cell_t ram_rdata,
    output dz_pkg::dz_row_t  row,
    output dz_pkg::dz_row_t  colg,
    output dz_pkg::dz_row_t  colr
);
    import dz_pkg::*;

    dz_cyc_t  cyc;
    dz_idx_t  row_idx;   // row on display now
    dz_row_t  rom_green;
    dz_cell_t pick;
    dz_cell_t next_cell;

    assign scan_row = row_idx + 3'd1;  // wraps 7 -> 0
    assign scan_req = ctrl.enable && cyc == '0;

    glyph_rom u_glyph_rom (
        .frame   (ctrl.frame),
        .row_idx (scan_row),
        .green   (rom_green)
    );

    always_comb
    begin
        if (ctrl.src_ram)
        begin
            pick.green = ram_rdata.green;
            pick.red   = ram_rdata.red | (ctrl.alarm ? ram_rdata.green : 8'h00);
        end
        else
        begin
            pick.green = rom_green;
            pick.red   = ctrl.alarm ? rom_green : 8'h00;  // alarm turns green to orange
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cyc <= '0;
        else if (cyc == dz_cyc_t'(ROW_CYCLES - 1))
            cyc <= '0;
        else
            cyc <= cyc + 1'b1;
    end

    // ram data valid one cycle after the request
    always_ff @(posedge clk)
    begin
        if (cyc == dz_cyc_t'(1))
            next_cell <= pick;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
            row     <= '1;
            colg    <= '0;
            colr    <= '0;
        end
        else if (!ctrl.enable)
        begin
            row_idx <= '0;
            row     <= '1;  // blank
            colg    <= '0;
            colr    <= '0;
        end
        else if (cyc == dz_cyc_t'(ROW_CYCLES - 1))
        begin
            row_idx <= scan_row;
            row     <= ~(dz_row_t'(1) << scan_row);
            colg    <= next_cell.green;
            colr    <= next_cell.red;
        end
    end

endmodule

// ==== apb_regs.sv ====
`timescale 1ns/1ps

module apb_regs (
    input  logic              clk,
    input  logic              rst,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp,
    output dz_pkg::dz_ctrl_t  ctrl,
    output logic              host_req,
    output logic              host_we,
    output dz_pkg::dz_idx_t   host_row,
    output dz_pkg::dz_cell_t  host_wdata,
    input  logic              host_gnt,
    input  dz_pkg::dz_cell_t  ram_rdata
);
    import apb_pkg::*;
    import dz_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_GNT, ST_RESPOND} apb_state_t;

    apb_state_t state;
    logic       setup;
    logic       is_ctrl;
    logic       is_win;
    logic       win_q;    // access targets the frame window
    logic       err_q;
    logic [7:0] ctrl_rd;

    assign setup   = req.psel && !req.penable;
    assign is_ctrl = req.paddr == CTRL_ADDR;
    assign is_win  = req.paddr[7:5] == FRAME_BASE[7:5] && req.paddr[1:0] == 2'b00;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            win_q <= 1'b0;
            err_q <= 1'b0;
            ctrl  <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (setup)
                    begin
                        win_q <= is_win;
                        err_q <= !is_win && !is_ctrl;
                        state <= is_win ? ST_WAIT_GNT : ST_RESPOND;
                    end
                ST_WAIT_GNT:
                    if (host_gnt)
                        state <= ST_RESPOND;  // write lands at this edge
                ST_RESPOND:
                begin
                    if (host_we && !win_q && !err_q)
                    begin
                        ctrl.enable  <= req.pwdata[0];
                        ctrl.alarm   <= req.pwdata[1];
                        ctrl.src_ram <= req.pwdata[2];
                        ctrl.frame   <= req.pwdata[7:4];
                    end
                    state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // captured in the setup phase
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && setup)
        begin
            host_we    <= req.pwrite;
            host_row   <= req.paddr[4:2];
            host_wdata <= req.pwdata[15:0];
        end
    end

    assign host_req = state == ST_WAIT_GNT;
    assign ctrl_rd  = {ctrl.frame, 1'b0, ctrl.src_ram, ctrl.alarm, ctrl.enable};

    always_comb
    begin
        rsp = '0;
        if (state == ST_RESPOND)
        begin
            rsp.pready  = 1'b1;
            rsp.pslverr = err_q;
            if (!host_we && !err_q)
                rsp.prdata = win_q ? {16'h0, ram_rdata} : {24'h0, ctrl_rd};
        end
    end

endmodule

// ==== frame_arbiter.sv ====
`timescale 1ns/1ps

module frame_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             scan_req,
    input  dz_pkg::dz_idx_t  scan_row,
    input  logic             host_req,
    input  logic             host_we,
    input  dz_pkg::dz_idx_t  host_row,
    input  dz_pkg::dz_cell_t host_wdata,
    output logic             host_gnt,
    output dz_pkg::dz_cell_t ram_rdata
);
    import dz_pkg::*;

    dz_idx_t  ram_addr;
    dz_cell_t ram_q;
    logic     ram_we;
    logic     scan_rd_q;
    logic     host_rd_q;

    // scanner always wins the port
    assign host_gnt = host_req && !scan_req;
    assign ram_we   = host_gnt && host_we;
    assign ram_addr = scan_req ? scan_row : host_row;

    // who read the port last cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_rd_q <= 1'b0;
            host_rd_q <= 1'b0;
        end
        else
        begin
            scan_rd_q <= scan_req;
            host_rd_q <= host_gnt && !host_we;
        end
    end

    assign ram_rdata = (scan_rd_q || host_rd_q) ? ram_q : '0;

    frame_ram u_frame_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (host_wdata),
        .rdata (ram_q)
    );

endmodule

// ==== frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram (
    input  logic             clk,
    input  logic             we,
    input  dz_pkg::dz_idx_t  addr,
    input  dz_pkg::dz_cell_t wdata,
    output dz_pkg::dz_cell_t rdata
);
    import dz_pkg::*;

    dz_cell_t mem [8];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
    end

    // registered read returns old data on a write cycle
    always_ff @(posedge clk)
    begin
        rdata <= mem[addr];
    end

endmodule

// ==== glyph_rom.sv ====
`timescale 1ns/1ps

module glyph_rom (
    input  dz_pkg::dz_frame_t frame,
    input  dz_pkg::dz_idx_t   row_idx,
    output dz_pkg::dz_row_t   green
);
    import dz_pkg::*;

    dz_row_t rows [8];

    // rows listed top to bottom with row 0 first
    always_comb
    begin
        case (frame)
            // growing blob
            4'd0:    rows = '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
                              8'b0011_1100, 8'b0001_1000, 8'b0000_0000, 8'b0000_0000};
            4'd1:    rows = '{8'b0000_0000, 8'b0000_0000, 8'b0011_1000, 8'b0111_1100,
                              8'b0111_1100, 8'b0011_1000, 8'b0000_0000, 8'b0000_0000};
            4'd2:    rows = '{8'b0000_0000, 8'b0000_0000, 8'b0011_1100, 8'b0111_1110,
                              8'b0111_1110, 8'b0011_1100, 8'b0000_0000, 8'b0000_0000};
            4'd3:    rows = '{8'b0000_0000, 8'b0011_1100, 8'b0111_1110, 8'b0111_1110,
                              8'b0111_1110, 8'b0111_1110, 8'b0011_1100, 8'b0000_0000};
            4'd4:    rows = '{8'b0011_1100, 8'b0111_1110, 8'b1111_1111, 8'b1111_1111,
                              8'b1111_1111, 8'b1111_1111, 8'b0111_1110, 8'b0011_1100};
            4'd5:    rows = '{default: 8'b1111_1111};  // full fill
            // flames
            4'd6:    rows = '{8'b1100_0011, 8'b1110_0011, 8'b1111_0001, 8'b1110_0011,
                              8'b1100_0111, 8'b1110_0111, 8'b1111_0111, 8'b1111_1011};
            4'd7:    rows = '{8'b0000_0000, 8'b0000_0001, 8'b1000_0001, 8'b1100_0011,
                              8'b1000_0011, 8'b1100_0111, 8'b1110_0111, 8'b1111_0011};
            4'd8:    rows = '{8'b0000_0000, 8'b0011_1000, 8'b0100_0100, 8'b0101_1010,
                              8'b0100_1010, 8'b0011_0010, 8'b1100_0100, 8'b0011_1000};
            // final shapes
            4'd9:    rows = '{8'b0000_0000, 8'b0000_0000, 8'b0110_0000, 8'b1111_1100,
                              8'b0011_1111, 8'b0011_1110, 8'b0001_1100, 8'b0000_0000};
            4'd10:   rows = '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
                              8'b0111_1110, 8'b0111_1110, 8'b0010_0100, 8'b0000_0000};
            4'd11:   rows = '{8'b1110_0000, 8'b0110_0000, 8'b1110_0000, 8'b0011_0000,
                              8'b0011_0001, 8'b0011_0011, 8'b0011_1110, 8'b0001_1100};
            default: rows = '{default: 8'b0000_0000};  // 12..15 blank
        endcase
    end

    assign green = rows[row_idx];

endmodule

// ==== apb_pkg.sv ====
package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [7:0] CTRL_ADDR  = 8'h00;
    localparam logic [7:0] FRAME_BASE = 8'h20;  // row r at FRAME_BASE + 4*r

endpackage

// ==== dz_pkg.sv ====
package dz_pkg;

    // clk cycles per row period
    localparam int ROW_CYCLES = 4;
    localparam int CYC_W      = $clog2(ROW_CYCLES);

    typedef logic [7:0]       dz_row_t;    // column byte or row select
    typedef logic [2:0]       dz_idx_t;    // row 0..7
    typedef logic [3:0]       dz_frame_t;  // frame 0..15
    typedef logic [CYC_W-1:0] dz_cyc_t;    // position inside a row period

    // one user frame row
    typedef struct packed {
        dz_row_t red;
        dz_row_t green;
    } dz_cell_t;

    typedef struct packed {
        dz_frame_t frame;
        logic      src_ram;  // 1 = user frame RAM, 0 = glyph ROM
        logic      alarm;
        logic      enable;
    } dz_ctrl_t;

endpackage
